// File: Makefile
# Verilator build and run for the operator slot controller

VERILATOR  := verilator
VFLAGS     := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_opl_operator_ctrl
RTL_TOP    := opl_operator_ctrl
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
PASS_MSG   := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tb_operator_model.sv
// ====================
// stand-in operator for the testbench
// returns a computable sample a fixed
// pipeline delay after each slot
// ====================
`include "opl_defs.svh"

module tb_operator_model
    import opl_pkg::*;
(
    input  logic       clk,
    input  logic       slot_valid,
    input  logic       slot_bank,
    input  op_num_t    slot_op,
    output op_sample_t op_result
);

    localparam int D = `OPL_PIPE_DELAY;

    int           sweep_cnt = 0;     // started sweeps
    logic [D-1:0] vld_p = '0;
    op_sample_t   res_p [D];

    always @(posedge clk) begin
        int sweep_now;
        sweep_now = sweep_cnt;
        if (slot_valid && !slot_bank && slot_op == '0) begin
            sweep_now = sweep_cnt + 1;    // first slot of a new sweep
        end
        sweep_cnt <= sweep_now;
        vld_p     <= {vld_p[D-2:0], slot_valid};
        res_p[0]  <= op_sample_t'((sweep_now * 37 + int'(slot_bank) * `OPL_OPS_PER_BANK
                                   + int'(slot_op)) % 4096);
        for (int i = 1; i < D; i++) begin
            res_p[i] <= res_p[i-1];
        end
    end

    assign op_result = vld_p[D-1] ? res_p[D-1] : '0;

endmodule

// File: bench/tb_opl_operator_ctrl.sv
// ====================
// testbench for the operator slot controller
// clock and reset, register write table,
// three sweeps with result stream checks,
// slot parameter checks, watchdog, summary
// ====================
`include "opl_defs.svh"

module tb_opl_operator_ctrl
    import opl_pkg::*;
();

    localparam int OPS      = `OPL_OPS_PER_BANK;
    localparam int NSLOTS   = `OPL_NUM_SLOTS;
    localparam int N_ROWS   = 25;
    localparam int N_SWEEPS = 3;
    localparam int WATCHDOG_CYCLES = N_SWEEPS * 50 + N_ROWS + 100;

    // register group a write should land in
    localparam logic [3:0] G_AVEKM   = 4'd0;
    localparam logic [3:0] G_KSL_TL  = 4'd1;
    localparam logic [3:0] G_AR_DR   = 4'd2;
    localparam logic [3:0] G_SL_RR   = 4'd3;
    localparam logic [3:0] G_WS      = 4'd4;
    localparam logic [3:0] G_FNUM_LO = 4'd5;
    localparam logic [3:0] G_KON_BLK = 4'd6;
    localparam logic [3:0] G_FB_CNT  = 4'd7;
    localparam logic [3:0] G_NONE    = 4'd15;

    typedef struct packed {
        logic       bank;
        logic [7:0] addr;
        logic [3:0] grp;
        op_num_t    op_a;    // operator that reads the entry
        op_num_t    op_b;    // second operator of the channel
        logic       cnt;     // forced cnt bit for 0xC0 writes
    } wr_row_t;

    localparam wr_row_t ROWS [N_ROWS] = '{
        '{1'b0, 8'h20, G_AVEKM,   5'd0,  5'd0,  1'b0},
        '{1'b0, 8'h28, G_AVEKM,   5'd6,  5'd6,  1'b0},
        '{1'b0, 8'h26, G_NONE,    5'd0,  5'd0,  1'b0},    // gap offset 6
        '{1'b0, 8'h27, G_NONE,    5'd0,  5'd0,  1'b0},    // gap offset 7
        '{1'b0, 8'h45, G_KSL_TL,  5'd5,  5'd5,  1'b0},
        '{1'b0, 8'h70, G_AR_DR,   5'd12, 5'd12, 1'b0},
        '{1'b0, 8'h95, G_SL_RR,   5'd17, 5'd17, 1'b0},
        '{1'b0, 8'hE9, G_WS,      5'd7,  5'd7,  1'b0},
        '{1'b0, 8'hA4, G_FNUM_LO, 5'd7,  5'd10, 1'b0},
        '{1'b0, 8'hB4, G_KON_BLK, 5'd7,  5'd10, 1'b0},
        '{1'b0, 8'hC4, G_FB_CNT,  5'd7,  5'd10, 1'b0},
        '{1'b0, 8'hC0, G_FB_CNT,  5'd0,  5'd3,  1'b1},
        '{1'b0, 8'h1F, G_NONE,    5'd0,  5'd0,  1'b0},    // below all groups
        '{1'b1, 8'h20, G_AVEKM,   5'd0,  5'd0,  1'b0},
        '{1'b1, 8'h30, G_AVEKM,   5'd12, 5'd12, 1'b0},
        '{1'b1, 8'h2E, G_NONE,    5'd0,  5'd0,  1'b0},    // gap offset 14
        '{1'b1, 8'h4C, G_KSL_TL,  5'd10, 5'd10, 1'b0},
        '{1'b1, 8'h63, G_AR_DR,   5'd3,  5'd3,  1'b0},
        '{1'b1, 8'h91, G_SL_RR,   5'd13, 5'd13, 1'b0},
        '{1'b1, 8'hF5, G_WS,      5'd17, 5'd17, 1'b0},
        '{1'b1, 8'hA8, G_FNUM_LO, 5'd14, 5'd17, 1'b0},
        '{1'b1, 8'hB8, G_KON_BLK, 5'd14, 5'd17, 1'b0},
        '{1'b1, 8'hC8, G_FB_CNT,  5'd14, 5'd17, 1'b0},
        '{1'b1, 8'hC2, G_FB_CNT,  5'd2,  5'd5,  1'b1},
        '{1'b1, 8'hF6, G_NONE,    5'd0,  5'd0,  1'b0}     // past the last group
    };

    logic       clk;
    logic       arst_n;
    logic       sample_clk_en;
    logic       reg_wr_valid;
    logic       reg_wr_bank;
    logic [7:0] reg_wr_addr;
    logic [7:0] reg_wr_data;
    op_sample_t op_result;
    logic       slot_valid;
    logic       slot_bank;
    op_num_t    slot_op;
    logic       am;
    logic       vib;
    logic       egt;
    logic       ksr;
    logic [3:0] mult;
    logic [1:0] ksl;
    logic [5:0] tl;
    logic [3:0] ar;
    logic [3:0] dr;
    logic [3:0] sl;
    logic [3:0] rr;
    logic [2:0] ws;
    logic [9:0] fnum;
    logic [2:0] block;
    logic       kon;
    logic [2:0] fb;
    op_sample_t modulation;
    logic       out_valid;
    logic       out_bank;
    op_num_t    out_op;
    op_sample_t out_sample;
    logic       ops_done;

    int         seed;
    int         err_count    = 0;
    int         test_start   = 0;
    int         tests_run    = 0;
    int         tests_failed = 0;
    int         sweep_no     = 0;
    logic [7:0] row_data [N_ROWS];

    // slot outputs of the last sweep indexed by bank * 18 + op
    logic [7:0] cap_avekm   [NSLOTS];
    logic [7:0] cap_ksl_tl  [NSLOTS];
    logic [7:0] cap_ar_dr   [NSLOTS];
    logic [7:0] cap_sl_rr   [NSLOTS];
    logic [2:0] cap_ws      [NSLOTS];
    logic [9:0] cap_fnum    [NSLOTS];
    logic [5:0] cap_kon_blk [NSLOTS];   // kon, block, fnum high bits
    logic [2:0] cap_fb      [NSLOTS];
    op_sample_t cap_mod     [NSLOTS];

    opl_operator_ctrl i_dut (.*);

    tb_operator_model i_model (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic compare_value(input logic [12:0] actual, input logic [12:0] expected,
                                 input string what);
        if (actual !== expected) begin
            $display("error at time %0t: %s is %0h, expected %0h", $time, what, actual,
                     expected);
            err_count++;
        end
    endtask

    task automatic check_idle();
        if (slot_valid !== 1'b0 || out_valid !== 1'b0 || ops_done !== 1'b0) begin
            $display("slot_valid, out_valid or ops_done high at time %0t before any start",
                     $time);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_count == test_start) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, err_count - test_start);
        end
        test_start = err_count;
    endtask

    task automatic check_table();
        int         a;
        int         b;
        int         prev;
        logic [7:0] d;
        string      tag;
        for (int i = 0; i < N_ROWS; i++) begin
            d   = row_data[i];
            a   = int'(ROWS[i].bank) * OPS + int'(ROWS[i].op_a);
            b   = int'(ROWS[i].bank) * OPS + int'(ROWS[i].op_b);
            tag = $sformatf("row %0d bank %0d op %0d", i, ROWS[i].bank, ROWS[i].op_a);
            case (ROWS[i].grp)
                G_AVEKM:  compare_value(13'(cap_avekm[a]), 13'(d), {tag, " flags/mult"});
                G_KSL_TL: compare_value(13'(cap_ksl_tl[a]), 13'(d), {tag, " ksl/tl"});
                G_AR_DR:  compare_value(13'(cap_ar_dr[a]), 13'(d), {tag, " ar/dr"});
                G_SL_RR:  compare_value(13'(cap_sl_rr[a]), 13'(d), {tag, " sl/rr"});
                G_WS:     compare_value(13'(cap_ws[a]), 13'(d[2:0]), {tag, " ws"});
                G_FNUM_LO: begin
                    compare_value(13'(cap_fnum[a][7:0]), 13'(d), {tag, " fnum low"});
                    compare_value(13'(cap_fnum[b][7:0]), 13'(d), {tag, " fnum low, second op"});
                end
                G_KON_BLK: begin
                    compare_value(13'(cap_kon_blk[a]), 13'(d[5:0]), {tag, " kon/block/fnum"});
                    compare_value(13'(cap_kon_blk[b]), 13'(d[5:0]),
                                  {tag, " kon/block, second op"});
                end
                G_FB_CNT: begin
                    compare_value(13'(cap_fb[a]), 13'(d[3:1]), {tag, " fb"});
                    compare_value(13'(cap_fb[b]), 13'd0, {tag, " fb, second op"});
                    compare_value(cap_mod[a], 13'd0, {tag, " modulation"});
                    if (sweep_no > 1) begin    // sample memory filled by the last sweep
                        prev = ((sweep_no - 1) * 37 + int'(ROWS[i].bank) * OPS
                                + int'(ROWS[i].op_b) - 3) % 4096;
                        compare_value(cap_mod[b], d[0] ? 13'd0 : 13'(prev),
                                      {tag, " modulation, second op"});
                    end
                end
                default: ;
            endcase
        end
    endtask

    task automatic run_sweep(input string name, input bit mid_strobe);
        int   cyc;
        int   idx;
        int   n_slot;
        int   n_res;
        int   n_done;
        int   tail;
        int   exp_bank;
        int   exp_op;
        logic last_out;
        cyc      = 0;
        n_slot   = 0;
        n_res    = 0;
        n_done   = 0;
        tail     = -1;
        last_out = 1'b0;
        sweep_no++;
        sample_clk_en = 1'b1;
        while (tail != 0) begin
            @(negedge clk);
            cyc++;
            sample_clk_en = mid_strobe && (cyc == 12);    // lands inside the sweep
            if (slot_valid) begin
                if (n_slot == 0 && cyc != 1) begin
                    $display("first slot came %0d cycles after the start strobe, not 1", cyc);
                    err_count++;
                end
                compare_value(13'(slot_bank), 13'(n_slot / OPS),
                              $sformatf("slot %0d bank", n_slot));
                compare_value(13'(slot_op), 13'(n_slot % OPS),
                              $sformatf("slot %0d op", n_slot));
                idx = int'(slot_bank) * OPS + int'(slot_op);
                if (idx < NSLOTS) begin
                    cap_avekm[idx]   = {am, vib, egt, ksr, mult};
                    cap_ksl_tl[idx]  = {ksl, tl};
                    cap_ar_dr[idx]   = {ar, dr};
                    cap_sl_rr[idx]   = {sl, rr};
                    cap_ws[idx]      = ws;
                    cap_fnum[idx]    = fnum;
                    cap_kon_blk[idx] = {kon, block, fnum[9:8]};
                    cap_fb[idx]      = fb;
                    cap_mod[idx]     = modulation;
                end
                n_slot++;
            end
            if (out_valid) begin
                if (n_res == 0 && cyc != 8) begin
                    $display("first result came %0d cycles after the start strobe, not 8", cyc);
                    err_count++;
                end
                if (n_res < NSLOTS) begin
                    exp_bank = n_res / OPS;
                    exp_op   = n_res % OPS;
                    compare_value(13'(out_bank), 13'(exp_bank),
                                  $sformatf("result %0d bank", n_res));
                    compare_value(13'(out_op), 13'(exp_op), $sformatf("result %0d op", n_res));
                    compare_value(out_sample, 13'((sweep_no * 37 + exp_bank * OPS + exp_op) % 4096),
                                  $sformatf("result %0d sample", n_res));
                end
                n_res++;
            end
            if (ops_done) begin
                n_done++;
                if (!last_out || cyc != 44) begin
                    $display("ops_done at cycle %0d did not follow the final result", cyc);
                    err_count++;
                end
                tail = 5;
            end
            last_out = out_valid;
            if (tail > 0) begin
                tail--;
            end
        end
        if (n_slot != NSLOTS || n_res != NSLOTS || n_done != 1) begin
            $display("%s gave %0d slots, %0d results and %0d done pulses instead of 36, 36, 1",
                     name, n_slot, n_res, n_done);
            err_count++;
        end
        check_table();
        finish_test(name);
    endtask

    initial begin
        seed          = 63634;
        arst_n        = 1'b0;
        sample_clk_en = 1'b0;
        reg_wr_valid  = 1'b0;
        reg_wr_bank   = 1'b0;
        reg_wr_addr   = '0;
        reg_wr_data   = '0;
        for (int i = 0; i < N_ROWS; i++) begin
            row_data[i] = 8'($random(seed));
            if (ROWS[i].grp == G_FB_CNT) begin
                row_data[i][0] = ROWS[i].cnt;
            end
        end
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        for (int i = 0; i < N_ROWS; i++) begin
            reg_wr_valid = 1'b1;
            reg_wr_bank  = ROWS[i].bank;
            reg_wr_addr  = ROWS[i].addr;
            reg_wr_data  = row_data[i];
            @(negedge clk);
            check_idle();
        end
        reg_wr_valid = 1'b0;
        finish_test("idle after reset and during writes");
        run_sweep("sweep 1", 1'b0);
        run_sweep("sweep 2 with mid-sweep strobe", 1'b1);
        run_sweep("sweep 3", 1'b0);
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+rtl
rtl/opl_pkg.sv
rtl/reg_bank_mem.sv
rtl/reg_file.sv
rtl/slot_sequencer.sv
rtl/op_return.sv
rtl/opl_operator_ctrl.sv
bench/tb_operator_model.sv
bench/tb_opl_operator_ctrl.sv

// File: rtl/op_return.sv
// ====================
// operator return path
// slot index delay line, sample memory for modulation,
// feedback and modulation select, result stream, done pulse
// ====================
`include "opl_defs.svh"

module op_return
    import opl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       slot_valid,
    input  logic       slot_bank,
    input  op_num_t    slot_op,
    input  logic [2:0] fb_in,
    input  logic       cnt,
    input  op_sample_t op_result,
    output logic [2:0] fb,
    output op_sample_t modulation,
    output logic       out_valid,
    output logic       out_bank,
    output op_num_t    out_op,
    output op_sample_t out_sample,
    output logic       ops_done
);

    localparam int D = `OPL_PIPE_DELAY;

    logic [D:1]          valid_p;
    logic [D:1]          bank_p;
    op_num_t [D:1]       op_p;
    logic                is_second;     // modulated operator of its channel
    op_num_t             mod_src_op;
    op_sample_t          mod_sample;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_p   <= '0;
            out_valid <= 1'b0;
            ops_done  <= 1'b0;
        end else begin
            valid_p   <= {valid_p[D-1:1], slot_valid};
            out_valid <= valid_p[D];
            ops_done  <= out_valid && !valid_p[D];  // falling edge of the stream
        end
    end

    always_ff @(posedge clk) begin
        bank_p     <= {bank_p[D-1:1], slot_bank};
        op_p       <= {op_p[D-1:1], slot_op};
        out_bank   <= bank_p[D];
        out_op     <= op_p[D];
        out_sample <= op_result;
    end

    // result of op-3 lands 3 cycles after this slot, so the read
    // still sees the previous sweep
    reg_bank_mem #(
        .DATA_WIDTH (`OPL_OP_OUT_WIDTH),
        .DEPTH      (`OPL_OPS_PER_BANK)
    ) i_sample_mem (
        .clk     (clk),
        .wr_en   (valid_p[D]),
        .wr_bank (bank_p[D]),
        .wr_addr (op_p[D]),
        .wr_data (op_result),
        .rd_bank (slot_bank),
        .rd_addr (mod_src_op),
        .rd_data (mod_sample)
    );

    always_comb begin
        is_second  = slot_op inside {5'd3, 5'd4, 5'd5, 5'd9, 5'd10, 5'd11,
                                     5'd15, 5'd16, 5'd17};
        mod_src_op = is_second ? op_num_t'(slot_op - 5'd3) : '0;
        fb         = is_second ? 3'd0 : fb_in;
        if (is_second && !cnt) begin
            modulation = mod_sample;    // fm chain from first operator
        end else begin
            modulation = '0;
        end
    end

endmodule

// File: rtl/opl_defs.svh
// ====================
// shared constants for the operator slot controller
// bank and slot counts, widths, register group bases,
// operator pipeline latency
// ====================
`ifndef OPL_DEFS_SVH
`define OPL_DEFS_SVH

`define OPL_NUM_BANKS       2
`define OPL_OPS_PER_BANK    18
`define OPL_CH_PER_BANK     9
`define OPL_NUM_SLOTS       (`OPL_NUM_BANKS * `OPL_OPS_PER_BANK)
`define OPL_OP_MEM_DEPTH    22    // offsets 0x00..0x15, with gaps
`define OPL_OP_OUT_WIDTH    13
`define OPL_PIPE_DELAY      6     // operator latency in cycles

// per-operator register groups
`define OPL_BASE_AVEKM      8'h20
`define OPL_BASE_KSL_TL     8'h40
`define OPL_BASE_AR_DR      8'h60
`define OPL_BASE_SL_RR      8'h80
`define OPL_BASE_WS         8'hE0

// per-channel register groups
`define OPL_BASE_FNUM_LO    8'hA0
`define OPL_BASE_KON_BLK    8'hB0
`define OPL_BASE_FB_CNT     8'hC0

`endif

// File: rtl/opl_operator_ctrl.sv
// ====================
// operator slot controller top level
// sequencer, register file and return path
// ====================
`include "opl_defs.svh"

module opl_operator_ctrl
    import opl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       sample_clk_en,
    input  logic       reg_wr_valid,
    input  logic       reg_wr_bank,
    input  logic [7:0] reg_wr_addr,
    input  logic [7:0] reg_wr_data,
    input  op_sample_t op_result,
    output logic       slot_valid,
    output logic       slot_bank,
    output op_num_t    slot_op,
    output logic       am,
    output logic       vib,
    output logic       egt,
    output logic       ksr,
    output logic [3:0] mult,
    output logic [1:0] ksl,
    output logic [5:0] tl,
    output logic [3:0] ar,
    output logic [3:0] dr,
    output logic [3:0] sl,
    output logic [3:0] rr,
    output logic [2:0] ws,
    output logic [9:0] fnum,
    output logic [2:0] block,
    output logic       kon,
    output logic [2:0] fb,
    output op_sample_t modulation,
    output logic       out_valid,
    output logic       out_bank,
    output op_num_t    out_op,
    output op_sample_t out_sample,
    output logic       ops_done
);

    op_addr_t   slot_op_addr;
    ch_num_t    slot_ch;
    logic [2:0] ch_fb;      // channel feedback before operator select
    logic       ch_cnt;

    slot_sequencer i_slot_sequencer (
        .clk          (clk),
        .arst_n       (arst_n),
        .sample_clk_en(sample_clk_en),
        .slot_valid   (slot_valid),
        .slot_bank    (slot_bank),
        .slot_op      (slot_op),
        .slot_op_addr (slot_op_addr),
        .slot_ch      (slot_ch)
    );

    reg_file i_reg_file (
        .clk          (clk),
        .reg_wr_valid (reg_wr_valid),
        .reg_wr_bank  (reg_wr_bank),
        .reg_wr_addr  (reg_wr_addr),
        .reg_wr_data  (reg_wr_data),
        .slot_bank    (slot_bank),
        .slot_op_addr (slot_op_addr),
        .slot_ch      (slot_ch),
        .am           (am),
        .vib          (vib),
        .egt          (egt),
        .ksr          (ksr),
        .mult         (mult),
        .ksl          (ksl),
        .tl           (tl),
        .ar           (ar),
        .dr           (dr),
        .sl           (sl),
        .rr           (rr),
        .ws           (ws),
        .fnum         (fnum),
        .block        (block),
        .kon          (kon),
        .fb           (ch_fb),
        .cnt          (ch_cnt)
    );

    op_return i_op_return (
        .clk        (clk),
        .arst_n     (arst_n),
        .slot_valid (slot_valid),
        .slot_bank  (slot_bank),
        .slot_op    (slot_op),
        .fb_in      (ch_fb),
        .cnt        (ch_cnt),
        .op_result  (op_result),
        .fb         (fb),
        .modulation (modulation),
        .out_valid  (out_valid),
        .out_bank   (out_bank),
        .out_op     (out_op),
        .out_sample (out_sample),
        .ops_done   (ops_done)
    );

endmodule

// File: rtl/opl_pkg.sv
// ====================
// types for the operator slot controller
// slot index types, operator sample type
// per-operator register byte with two views
// ====================
`include "opl_defs.svh"

package opl_pkg;

    typedef logic [4:0] op_num_t;     // operator within a bank
    typedef logic [4:0] op_addr_t;    // register offset, gapped
    typedef logic [3:0] ch_num_t;     // channel within a bank

    typedef logic signed [`OPL_OP_OUT_WIDTH-1:0] op_sample_t;

    // 0x20 group layout
    typedef struct packed {
        logic       am;     // tremolo on
        logic       vib;    // vibrato on
        logic       egt;    // sustain hold
        logic       ksr;    // key scale rate
        logic [3:0] mult;   // frequency multiplier
    } op_flag_view_t;

    // 0x40 group layout
    typedef struct packed {
        logic [1:0] ksl;    // key scale level
        logic [5:0] tl;     // total level
    } op_level_view_t;

    // one register byte, read through the view of its group
    typedef union packed {
        op_flag_view_t  flag;
        op_level_view_t level;
    } op_reg_byte_u;

endpackage

// File: rtl/reg_bank_mem.sv
// ====================
// two-bank register memory
// one synchronous write port, one combinational read port
// ====================
`include "opl_defs.svh"

module reg_bank_mem #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH      = 22
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic                     wr_bank,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0]    wr_data,
    input  logic                     rd_bank,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [DATA_WIDTH-1:0]    rd_data
);

    logic [DATA_WIDTH-1:0] mem [`OPL_NUM_BANKS][DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_data;
        end
    end

    // read is visible the cycle after a write to the same entry
    assign rd_data = mem[rd_bank][rd_addr];

endmodule

// File: rtl/reg_file.sv
// ====================
// register file
// decodes host writes into the operator and channel
// parameter memories, reads them for the current slot
// ====================
`include "opl_defs.svh"

module reg_file
    import opl_pkg::*;
(
    input  logic       clk,
    input  logic       reg_wr_valid,
    input  logic       reg_wr_bank,
    input  logic [7:0] reg_wr_addr,
    input  logic [7:0] reg_wr_data,
    input  logic       slot_bank,
    input  op_addr_t   slot_op_addr,
    input  ch_num_t    slot_ch,
    output logic       am,
    output logic       vib,
    output logic       egt,
    output logic       ksr,
    output logic [3:0] mult,
    output logic [1:0] ksl,
    output logic [5:0] tl,
    output logic [3:0] ar,
    output logic [3:0] dr,
    output logic [3:0] sl,
    output logic [3:0] rr,
    output logic [2:0] ws,
    output logic [9:0] fnum,
    output logic [2:0] block,
    output logic       kon,
    output logic [2:0] fb,
    output logic       cnt
);

    localparam logic [7:0] OP_BASE [4] = '{
        `OPL_BASE_AVEKM,
        `OPL_BASE_KSL_TL,
        `OPL_BASE_AR_DR,
        `OPL_BASE_SL_RR
    };

    logic [7:0]   op_word [4];     // full-byte operator groups
    op_reg_byte_u avekm_byte;
    op_reg_byte_u ksl_tl_byte;
    logic [2:0]   ws_word;
    logic [7:0]   fnum_lo_word;
    logic [5:0]   kon_blk_word;    // kon, block, fnum[9:8]
    logic [3:0]   fb_cnt_word;     // fb, cnt
    logic [7:0]   ws_off;
    logic [7:0]   fnum_lo_off;
    logic [7:0]   kon_blk_off;
    logic [7:0]   fb_cnt_off;

    // offsets wrap below the base, so one compare checks both ends
    assign ws_off      = reg_wr_addr - `OPL_BASE_WS;
    assign fnum_lo_off = reg_wr_addr - `OPL_BASE_FNUM_LO;
    assign kon_blk_off = reg_wr_addr - `OPL_BASE_KON_BLK;
    assign fb_cnt_off  = reg_wr_addr - `OPL_BASE_FB_CNT;

    for (genvar g = 0; g < 4; g++) begin : g_op_mem
        logic [7:0] wr_off;

        assign wr_off = reg_wr_addr - OP_BASE[g];

        reg_bank_mem #(.DATA_WIDTH(8), .DEPTH(`OPL_OP_MEM_DEPTH)) i_mem (
            .clk     (clk),
            .wr_en   (reg_wr_valid && wr_off < `OPL_OP_MEM_DEPTH),
            .wr_bank (reg_wr_bank),
            .wr_addr (op_addr_t'(wr_off)),
            .wr_data (reg_wr_data),
            .rd_bank (slot_bank),
            .rd_addr (slot_op_addr),
            .rd_data (op_word[g])
        );
    end

    reg_bank_mem #(.DATA_WIDTH(3), .DEPTH(`OPL_OP_MEM_DEPTH)) i_ws_mem (
        .clk     (clk),
        .wr_en   (reg_wr_valid && ws_off < `OPL_OP_MEM_DEPTH),
        .wr_bank (reg_wr_bank),
        .wr_addr (op_addr_t'(ws_off)),
        .wr_data (reg_wr_data[2:0]),
        .rd_bank (slot_bank),
        .rd_addr (slot_op_addr),
        .rd_data (ws_word)
    );

    reg_bank_mem #(.DATA_WIDTH(8), .DEPTH(`OPL_CH_PER_BANK)) i_fnum_lo_mem (
        .clk     (clk),
        .wr_en   (reg_wr_valid && fnum_lo_off < `OPL_CH_PER_BANK),
        .wr_bank (reg_wr_bank),
        .wr_addr (ch_num_t'(fnum_lo_off)),
        .wr_data (reg_wr_data),
        .rd_bank (slot_bank),
        .rd_addr (slot_ch),
        .rd_data (fnum_lo_word)
    );

    reg_bank_mem #(.DATA_WIDTH(6), .DEPTH(`OPL_CH_PER_BANK)) i_kon_blk_mem (
        .clk     (clk),
        .wr_en   (reg_wr_valid && kon_blk_off < `OPL_CH_PER_BANK),
        .wr_bank (reg_wr_bank),
        .wr_addr (ch_num_t'(kon_blk_off)),
        .wr_data (reg_wr_data[5:0]),
        .rd_bank (slot_bank),
        .rd_addr (slot_ch),
        .rd_data (kon_blk_word)
    );

    reg_bank_mem #(.DATA_WIDTH(4), .DEPTH(`OPL_CH_PER_BANK)) i_fb_cnt_mem (
        .clk     (clk),
        .wr_en   (reg_wr_valid && fb_cnt_off < `OPL_CH_PER_BANK),
        .wr_bank (reg_wr_bank),
        .wr_addr (ch_num_t'(fb_cnt_off)),
        .wr_data (reg_wr_data[3:0]),
        .rd_bank (slot_bank),
        .rd_addr (slot_ch),
        .rd_data (fb_cnt_word)
    );

    assign avekm_byte  = op_word[0];
    assign ksl_tl_byte = op_word[1];

    assign am    = avekm_byte.flag.am;
    assign vib   = avekm_byte.flag.vib;
    assign egt   = avekm_byte.flag.egt;
    assign ksr   = avekm_byte.flag.ksr;
    assign mult  = avekm_byte.flag.mult;
    assign ksl   = ksl_tl_byte.level.ksl;
    assign tl    = ksl_tl_byte.level.tl;
    assign ar    = op_word[2][7:4];
    assign dr    = op_word[2][3:0];
    assign sl    = op_word[3][7:4];
    assign rr    = op_word[3][3:0];
    assign ws    = ws_word;
    assign fnum  = {kon_blk_word[1:0], fnum_lo_word};
    assign block = kon_blk_word[4:2];
    assign kon   = kon_blk_word[5];
    assign fb    = fb_cnt_word[3:1];
    assign cnt   = fb_cnt_word[0];

endmodule

// File: rtl/slot_sequencer.sv
// ====================
// slot sequencer
// steps through the 36 operator slots per sample strobe
// and maps each slot to register offset and channel
// ====================
`include "opl_defs.svh"

module slot_sequencer
    import opl_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     sample_clk_en,
    output logic     slot_valid,
    output logic     slot_bank,
    output op_num_t  slot_op,
    output op_addr_t slot_op_addr,
    output ch_num_t  slot_ch
);

    localparam int STATE_W = $clog2(`OPL_NUM_SLOTS + 1);

    logic [STATE_W-1:0] state;        // 0 idle, 1..36 slots
    logic [STATE_W-1:0] next_state;
    logic [1:0]         op_group;     // third of the bank
    logic [2:0]         op_in_grp;
    logic [1:0]         op_in_ch;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= '0;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        if (state == '0) begin
            next_state = sample_clk_en ? STATE_W'(1) : '0;
        end else if (state == STATE_W'(`OPL_NUM_SLOTS)) begin
            next_state = '0;
        end else begin
            next_state = state + STATE_W'(1);   // strobes mid-sweep ignored
        end
    end

    always_comb begin
        slot_valid = (state != '0);
        slot_bank  = (state > STATE_W'(`OPL_OPS_PER_BANK));
        if (slot_bank) begin
            slot_op = op_num_t'(state - STATE_W'(`OPL_OPS_PER_BANK + 1));
        end else if (slot_valid) begin
            slot_op = op_num_t'(state - STATE_W'(1));
        end else begin
            slot_op = '0;
        end
    end

    // offsets skip two entries after each group of six
    always_comb begin
        if (slot_op < 5'd6) begin
            op_group = 2'd0;
        end else if (slot_op < 5'd12) begin
            op_group = 2'd1;
        end else begin
            op_group = 2'd2;
        end
        op_in_grp    = 3'(slot_op - 5'd6 * op_group);
        op_in_ch     = (op_in_grp >= 3'd3) ? 2'(op_in_grp - 3'd3) : op_in_grp[1:0];
        slot_op_addr = op_addr_t'(slot_op + 5'd2 * op_group);
        slot_ch      = ch_num_t'(4'd3 * op_group + op_in_ch);
    end

endmodule
